// File: aer_arbiter.f
+incdir+.
aer_arbiter_pkg.sv
rr_arbiter.sv
pixel_groups.sv
wall_clock.sv
event_encoder.sv
aer_regs.sv
aer_top.sv
tb_aer.sv

// File: aer_arbiter_consts.svh
// array geometry, timestamp width and APB register map macros
`ifndef AER_ARBITER_CONSTS_SVH
`define AER_ARBITER_CONSTS_SVH

// pixel array shape
`define AER_ROWS 8
`define AER_COLS 8

// level-0 tiles are square, 2x2 pixels
`define AER_GRP_SIDE 2
// (rows/side) * (cols/side)
`define AER_NUM_GRP 16

// wall clock width, also the timestamp field of an event
`define AER_TS_W 16

// APB byte addresses, 5-bit paddr
`define AER_REG_CTRL    5'h00
`define AER_REG_POLMASK 5'h04
`define AER_REG_TSDIV   5'h08
// read-only
`define AER_REG_EVTCNT  5'h0C
`define AER_REG_STATUS  5'h10

`endif

// File: aer_arbiter_pkg.sv
// shared packed structs: event word, configuration, APB request/response, pixel arrays
`include "aer_arbiter_consts.svh"

package aer_arbiter_pkg;

    // one address event as delivered on the output port
    typedef struct packed {
        logic [$clog2(`AER_ROWS)-1:0] row;
        logic [$clog2(`AER_COLS)-1:0] col;
        // 1 = ON, 0 = OFF
        logic                         polarity;
        logic [`AER_TS_W-1:0]         timestamp;
    } event_t;

    // register block to core
    typedef struct packed {
        logic       enable;
        logic       on_en;
        logic       off_en;
        // timestamp ticks every ts_div+1 cycles
        logic [7:0] ts_div;
        // single-cycle pulse
        logic       ts_clear;
    } aer_cfg_t;

    // APB master side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB slave side, no pslverr
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    // per pixel: bit 0 ON, bit 1 OFF
    typedef logic [`AER_ROWS-1:0][`AER_COLS-1:0][1:0] pixel_req_t;
    // one grant bit per pixel
    typedef logic [`AER_ROWS-1:0][`AER_COLS-1:0] pixel_gnt_t;

endpackage

// File: aer_regs.sv
// APB register block: configuration, timestamp clear pulse, event counter, status
`timescale 1ns/1ps
`include "aer_arbiter_consts.svh"

module aer_regs
    import aer_arbiter_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  apb_req_t apb_req_i,
    input  logic     evt_fire_i,
    input  logic     busy_i,
    output apb_rsp_t apb_rsp_o,
    output aer_cfg_t cfg_o
);

    logic        access;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] evt_cnt;

    // second phase of a transfer, always zero wait
    assign access = apb_req_i.psel & apb_req_i.penable;
    assign wr_en  = access & apb_req_i.pwrite;
    assign rd_en  = access & ~apb_req_i.pwrite;

    // configuration registers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_o.enable   <= 1'b0;
            cfg_o.on_en    <= 1'b1;
            cfg_o.off_en   <= 1'b1;
            cfg_o.ts_div   <= '0;
            cfg_o.ts_clear <= 1'b0;
        end else begin
            // ts_clear self-clears after one cycle
            cfg_o.ts_clear <= 1'b0;
            if (wr_en) begin
                case (apb_req_i.paddr)
                    `AER_REG_CTRL: begin
                        cfg_o.enable   <= apb_req_i.pwdata[0];
                        cfg_o.ts_clear <= apb_req_i.pwdata[1];
                    end
                    `AER_REG_POLMASK: begin
                        cfg_o.on_en  <= apb_req_i.pwdata[0];
                        cfg_o.off_en <= apb_req_i.pwdata[1];
                    end
                    `AER_REG_TSDIV: begin
                        cfg_o.ts_div <= apb_req_i.pwdata[7:0];
                    end
                    // EVTCNT and STATUS ignore writes
                    default: begin
                    end
                endcase
            end
        end
    end

    // one count per captured event
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            evt_cnt <= '0;
        end else if (evt_fire_i) begin
            evt_cnt <= evt_cnt + 1'b1;
        end
    end

    // read mux, zero outside a read
    always_comb begin
        apb_rsp_o.prdata = '0;
        apb_rsp_o.pready = 1'b1;
        if (rd_en) begin
            case (apb_req_i.paddr)
                // ts_clear reads back as 0
                `AER_REG_CTRL:    apb_rsp_o.prdata = {31'b0, cfg_o.enable};
                `AER_REG_POLMASK: apb_rsp_o.prdata = {30'b0, cfg_o.off_en, cfg_o.on_en};
                `AER_REG_TSDIV:   apb_rsp_o.prdata = {24'b0, cfg_o.ts_div};
                `AER_REG_EVTCNT:  apb_rsp_o.prdata = evt_cnt;
                `AER_REG_STATUS:  apb_rsp_o.prdata = {31'b0, busy_i};
                default:          apb_rsp_o.prdata = '0;
            endcase
        end
    end

    // every access phase follows a setup phase
    a_apb_phase : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_req_i.penable |-> apb_req_i.psel && $past(apb_req_i.psel)
                              && !$past(apb_req_i.penable)
    ) else $error("aer_regs: penable without a preceding setup phase");

endmodule

// File: aer_top.sv
// top level: registers, level-0 groups, root arbiter, wall clock, event encoder
`timescale 1ns/1ps
`include "aer_arbiter_consts.svh"

module aer_top
    import aer_arbiter_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  apb_req_t   apb_req_i,
    input  pixel_req_t req_i,
    input  logic       evt_ready_i,
    output apb_rsp_t   apb_rsp_o,
    output pixel_gnt_t gnt_o,
    output event_t     evt_o,
    output logic       evt_valid_o
);

    aer_cfg_t                         cfg;
    logic [`AER_NUM_GRP-1:0]          grp_req;
    // one-hot root choice
    logic [`AER_NUM_GRP-1:0]          grp_sel;
    logic [`AER_NUM_GRP-1:0][1:0]     local_idx;
    logic [`AER_NUM_GRP-1:0]          masked_pol;
    logic [`AER_TS_W-1:0]             timestamp;
    // capture strobe, drives pointers and counter
    logic                             evt_fire;
    logic                             busy;

    aer_regs u_regs (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .apb_req_i  (apb_req_i),
        .evt_fire_i (evt_fire),
        .busy_i     (busy),
        .apb_rsp_o  (apb_rsp_o),
        .cfg_o      (cfg)
    );

    pixel_groups u_groups (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_i        (cfg),
        .req_i        (req_i),
        .grp_sel_i    (grp_sel),
        .fire_i       (evt_fire),
        .grp_req_o    (grp_req),
        .local_idx_o  (local_idx),
        .masked_pol_o (masked_pol)
    );

    // level 1, picks one group
    rr_arbiter #(
        .N(`AER_NUM_GRP)
    ) u_root_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (grp_req),
        .advance_i (evt_fire),
        .gnt_o     (grp_sel)
    );

    wall_clock u_clock (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg),
        .timestamp_o (timestamp)
    );

    event_encoder u_encoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_i        (cfg),
        .grp_sel_i    (grp_sel),
        .local_idx_i  (local_idx),
        .masked_pol_i (masked_pol),
        .timestamp_i  (timestamp),
        .evt_ready_i  (evt_ready_i),
        .fire_o       (evt_fire),
        .busy_o       (busy),
        .gnt_o        (gnt_o),
        .evt_o        (evt_o),
        .evt_valid_o  (evt_valid_o)
    );

endmodule

// File: event_encoder.sv
// event capture, pixel grant pulse and valid/ready event output
`timescale 1ns/1ps
`include "aer_arbiter_consts.svh"

module event_encoder
    import aer_arbiter_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  aer_cfg_t                      cfg_i,
    input  logic [`AER_NUM_GRP-1:0]       grp_sel_i,
    input  logic [`AER_NUM_GRP-1:0][1:0]  local_idx_i,
    input  logic [`AER_NUM_GRP-1:0]       masked_pol_i,
    input  logic [`AER_TS_W-1:0]          timestamp_i,
    input  logic                          evt_ready_i,
    output logic                          fire_o,
    output logic                          busy_o,
    output pixel_gnt_t                    gnt_o,
    output event_t                        evt_o,
    output logic                          evt_valid_o
);

    localparam int GPR = `AER_COLS / `AER_GRP_SIDE;

    logic [$clog2(`AER_NUM_GRP)-1:0] grp_idx;
    logic [1:0]                      loc;
    event_t                          evt_nxt;
    pixel_gnt_t                      gnt_nxt;

    // output slot empty or being drained this edge
    assign fire_o = (!evt_valid_o || evt_ready_i) && cfg_i.enable && |grp_sel_i;

    // holding an event or something waiting
    assign busy_o = evt_valid_o | (|grp_sel_i);

    // root choice is one-hot
    always_comb begin
        grp_idx = '0;
        for (int g = 0; g < `AER_NUM_GRP; g++) begin
            if (grp_sel_i[g]) begin
                grp_idx = ($clog2(`AER_NUM_GRP))'(g);
            end
        end
    end

    assign loc = local_idx_i[grp_idx];

    // tile position plus offset inside the tile
    always_comb begin
        evt_nxt.row       = ($bits(evt_nxt.row))'((grp_idx / GPR) * `AER_GRP_SIDE
                                                  + loc / `AER_GRP_SIDE);
        evt_nxt.col       = ($bits(evt_nxt.col))'((grp_idx % GPR) * `AER_GRP_SIDE
                                                  + loc % `AER_GRP_SIDE);
        evt_nxt.polarity  = masked_pol_i[grp_idx];
        evt_nxt.timestamp = timestamp_i;
        gnt_nxt           = '0;
        gnt_nxt[evt_nxt.row][evt_nxt.col] = 1'b1;
    end

    // control: valid and the single-cycle grant
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            evt_valid_o <= 1'b0;
            gnt_o       <= '0;
        end else if (fire_o) begin
            evt_valid_o <= 1'b1;
            gnt_o       <= gnt_nxt;
        end else begin
            gnt_o <= '0;
            if (evt_ready_i) begin
                evt_valid_o <= 1'b0;
            end
        end
    end

    // payload, held until next capture
    always_ff @(posedge clk_i) begin
        if (fire_o) begin
            evt_o <= evt_nxt;
        end
    end

    // stalled event keeps its word and its valid
    a_stall_stable : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        evt_valid_o && !evt_ready_i |=> evt_valid_o && $stable(evt_o)
    ) else $error("event_encoder: event changed while stalled");

    // a pixel is never granted on two consecutive cycles
    a_gnt_pulse : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        |gnt_o |=> (gnt_o & $past(gnt_o)) == '0
    ) else $error("event_encoder: grant held longer than one cycle");

endmodule

// File: pixel_groups.sv
// level-0 arbitration: polarity masking and one round-robin arbiter per 2x2 group
`timescale 1ns/1ps
`include "aer_arbiter_consts.svh"

module pixel_groups
    import aer_arbiter_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  aer_cfg_t                          cfg_i,
    input  pixel_req_t                        req_i,
    input  logic [`AER_NUM_GRP-1:0]           grp_sel_i,
    input  logic                              fire_i,
    output logic [`AER_NUM_GRP-1:0]           grp_req_o,
    output logic [`AER_NUM_GRP-1:0][1:0]      local_idx_o,
    output logic [`AER_NUM_GRP-1:0]           masked_pol_o
);

    // groups per tile row
    localparam int GPR   = `AER_COLS / `AER_GRP_SIDE;
    // pixels per group
    localparam int GRP_N = `AER_GRP_SIDE * `AER_GRP_SIDE;

    for (genvar g = 0; g < `AER_NUM_GRP; g++) begin : g_grp
        // masked requests, ON part, and arbiter grant, by local index
        logic [GRP_N-1:0] loc_req;
        logic [GRP_N-1:0] loc_on;
        logic [GRP_N-1:0] loc_gnt;

        for (genvar l = 0; l < GRP_N; l++) begin : g_pix
            // pixel coordinates of local index l in group g
            localparam int R = (g / GPR) * `AER_GRP_SIDE + l / `AER_GRP_SIDE;
            localparam int C = (g % GPR) * `AER_GRP_SIDE + l % `AER_GRP_SIDE;

            assign loc_on[l]  = req_i[R][C][0] & cfg_i.on_en;
            // OFF only counts when accepted too
            assign loc_req[l] = loc_on[l] | (req_i[R][C][1] & cfg_i.off_en);
        end

        // in-group winner, pointer moves only when root picks this group
        rr_arbiter #(
            .N(GRP_N)
        ) u_grp_arb (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .req_i     (loc_req),
            .advance_i (fire_i & grp_sel_i[g]),
            .gnt_o     (loc_gnt)
        );

        // any pixel pending in the tile
        assign grp_req_o[g] = |loc_req;

        // one-hot to binary, 4 entries
        assign local_idx_o[g] = {loc_gnt[3] | loc_gnt[2], loc_gnt[3] | loc_gnt[1]};

        // ON wins when both polarities are pending
        assign masked_pol_o[g] = |(loc_gnt & loc_on);
    end

endmodule

// File: rr_arbiter.sv
// round-robin arbiter with a rotating priority pointer
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int N = 4
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic [N-1:0] req_i,
    input  logic         advance_i,
    output logic [N-1:0] gnt_o
);

    localparam int PW = (N > 1) ? $clog2(N) : 1;

    // highest priority index
    logic [PW-1:0] ptr;
    // binary index of the current grant
    logic [PW-1:0] win_idx;

    // scan cyclically from the pointer, first requester wins
    always_comb begin
        int   idx;
        logic found;
        gnt_o   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (!found && req_i[idx]) begin
                found       = 1'b1;
                gnt_o[idx]  = 1'b1;
                win_idx     = PW'(idx);
            end
        end
    end

    // pointer moves one past the winner, only when told to
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr <= '0;
        end else if (advance_i && |gnt_o) begin
            ptr <= (win_idx == PW'(N - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    // grant one-hot or idle, never to a silent requester
    a_gnt_legal : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0)
    ) else $error("rr_arbiter: illegal grant %b for req %b", gnt_o, req_i);

    // after an advance the winner loses priority to any other requester
    a_ptr_moves : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (advance_i && |gnt_o && $countones(req_i) > 1 && $stable(req_i)) ##1 $stable(req_i)
            |-> gnt_o != $past(gnt_o)
    ) else $error("rr_arbiter: pointer did not rotate");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the aer_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_aer \
    -f aer_arbiter.f -Mdir obj_dir -o tb_aer > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/tb_aer > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$SIM_LOG"; then
    exit 1
fi

if ! grep -q "Done: no errors" "$SIM_LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: tb_aer.sv
// testbench for aer_top: clock, APB driver, pixel model, event sink, checking assertions
`timescale 1ns/1ps
`include "aer_arbiter_consts.svh"

module tb_aer
    import aer_arbiter_pkg::*;
();

    logic       clk_i;
    logic       rst_n_i;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    pixel_req_t req;
    // requests as the DUT saw them at the last rising edge
    pixel_req_t req_q;
    pixel_gnt_t gnt;
    event_t     evt;
    logic       evt_valid;
    logic       evt_ready;
    logic       hs;

    int errors   = 0;
    int hs_cnt   = 0;
    int cyc      = 0;
    int clr_cnt  = 0;
    int last_clr = 0;
    int clr_cyc  = 0;
    int ts_div_sh = 0;
    logic [`AER_TS_W-1:0] last_ts = '0;
    // phase enables for the checks
    bit chk_disabled = 1'b0;
    bit chk_order    = 1'b0;
    bit chk_ts_bound = 1'b0;
    // shadow of the polarity masks
    bit on_sh  = 1'b1;
    bit off_sh = 1'b1;

    aer_top DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .apb_req_i   (apb_req),
        .req_i       (req),
        .evt_ready_i (evt_ready),
        .apb_rsp_o   (apb_rsp),
        .gnt_o       (gnt),
        .evt_o       (evt),
        .evt_valid_o (evt_valid)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    assign hs = evt_valid & evt_ready;

    // cycle count, handshake count, last delivered timestamp, captured requests
    always @(posedge clk_i) begin
        cyc   <= cyc + 1;
        req_q <= req;
        if (rst_n_i && hs) begin
            hs_cnt   <= hs_cnt + 1;
            last_ts  <= evt.timestamp;
            last_clr <= clr_cnt;
        end
    end

    function automatic bit accepted(input logic [1:0] kind, input bit on_m, input bit off_m);
        return (kind[0] && on_m) || (kind[1] && off_m);
    endfunction

    // k-th event of a full sweep: group k mod 16, local index k / 16
    function automatic logic [2:0] exp_row(input int k);
        return 3'(((k % `AER_NUM_GRP) / 4) * 2 + (k / `AER_NUM_GRP) / 2);
    endfunction

    function automatic logic [2:0] exp_col(input int k);
        return 3'(((k % `AER_NUM_GRP) % 4) * 2 + (k / `AER_NUM_GRP) % 2);
    endfunction

    function automatic pixel_req_t all_on();
        pixel_req_t b;
        for (int r = 0; r < `AER_ROWS; r++) begin
            for (int c = 0; c < `AER_COLS; c++) begin
                b[r][c] = 2'b01;
            end
        end
        return b;
    endfunction

    // cycles ON, OFF, both across the array
    function automatic pixel_req_t mixed_batch();
        pixel_req_t b;
        for (int r = 0; r < `AER_ROWS; r++) begin
            for (int c = 0; c < `AER_COLS; c++) begin
                b[r][c] = 2'((r * `AER_COLS + c) % 3 + 1);
            end
        end
        return b;
    endfunction

    function automatic pixel_req_t random_batch();
        pixel_req_t b;
        for (int r = 0; r < `AER_ROWS; r++) begin
            for (int c = 0; c < `AER_COLS; c++) begin
                b[r][c] = 2'($urandom % 4);
            end
        end
        return b;
    endfunction

    // two-phase APB transfer, starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        @(negedge clk_i);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_i);
        apb_req.penable = 1'b1;
        // inside the access phase, registers only move at the rising edge
        #1;
        rdata = apb_rsp.prdata;
        assert (apb_rsp.pready) else begin
            errors++;
            $display("Error: pready = 0x%h in access phase", apb_rsp.pready);
        end
        @(negedge clk_i);
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        apb_xfer(1'b0, addr, '0, data);
        assert (data == exp) else begin
            errors++;
            $display("Error: prdata of %s = 0x%08h, expected 0x%08h", name, data, exp);
        end
    endtask

    // pixel model and event sink: load a batch, drop each request on its grant
    task automatic run_batch(input pixel_req_t batch, input bit rand_ready);
        int hits [`AER_ROWS][`AER_COLS];
        int left;
        int exp_hits;
        bit busy;
        hits = '{default: 0};
        left = 2000;
        busy = 1'b1;
        req  = batch;
        while (busy && left > 0) begin
            @(negedge clk_i);
            left--;
            busy = 1'b0;
            for (int r = 0; r < `AER_ROWS; r++) begin
                for (int c = 0; c < `AER_COLS; c++) begin
                    if (gnt[r][c]) begin
                        hits[r][c]++;
                        req[r][c] = 2'b00;
                    end
                    if (accepted(req[r][c], on_sh, off_sh)) begin
                        busy = 1'b1;
                    end
                end
            end
            evt_ready = rand_ready ? ($urandom % 3 != 0) : 1'b1;
            busy = busy || evt_valid;
        end
        if (busy) begin
            errors++;
            $display("timeout: batch of pixel events not drained within 2000 cycles");
        end
        req = '0;
        // each accepted pixel granted once, masked ones never
        for (int r = 0; r < `AER_ROWS; r++) begin
            for (int c = 0; c < `AER_COLS; c++) begin
                exp_hits = accepted(batch[r][c], on_sh, off_sh) ? 1 : 0;
                assert (hits[r][c] == exp_hits) else begin
                    errors++;
                    $display("Error: gnt_o[%0d][%0d] pulses = 0x%h, expected 0x%h",
                             r, c, hits[r][c], exp_hits);
                end
            end
        end
    endtask

    // quiet while disabled
    a_disabled : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        chk_disabled |-> gnt == '0 && !evt_valid)
        else begin
            errors++;
            $display("Error: gnt_o = 0x%h, evt_valid_o = 0x%h while disabled",
                     $sampled(gnt), $sampled(evt_valid));
        end

    // stalled word holds, no grant under back-pressure
    a_stall : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        evt_valid && !evt_ready |=> evt_valid && $stable(evt) && gnt == '0)
        else begin
            errors++;
            $display("Error: evt_o = 0x%h, gnt_o = 0x%h after a stalled cycle",
                     $sampled(evt), $sampled(gnt));
        end

    // grant pulse belongs to the pixel of the new event, requesting at capture
    a_gnt_pixel : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        |gnt |-> $onehot(gnt) && evt_valid && gnt[evt.row][evt.col]
                 && accepted(req_q[evt.row][evt.col], on_sh, off_sh))
        else begin
            errors++;
            $display("Error: gnt_o = 0x%h does not match evt_o = 0x%h or an accepted request",
                     $sampled(gnt), $sampled(evt));
        end

    // ON wins when accepted
    a_polarity : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        |gnt |-> evt.polarity == (req_q[evt.row][evt.col][0] && on_sh))
        else begin
            errors++;
            $display("Error: evt_o.polarity = 0x%h, pixel request 0x%h",
                     $sampled(evt.polarity), $sampled(req_q[evt.row][evt.col]));
        end

    a_order : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        chk_order && hs |-> evt.row == exp_row(hs_cnt) && evt.col == exp_col(hs_cnt))
        else begin
            errors++;
            $display("Error: evt_o row/col = 0x%h/0x%h, expected 0x%h/0x%h",
                     $sampled(evt.row), $sampled(evt.col),
                     exp_row($sampled(hs_cnt)), exp_col($sampled(hs_cnt)));
        end

    a_ts_mono : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hs && clr_cnt == last_clr |-> evt.timestamp >= last_ts)
        else begin
            errors++;
            $display("Error: evt_o.timestamp = 0x%h below previous 0x%h",
                     $sampled(evt.timestamp), $sampled(last_ts));
        end

    // elapsed cycles since the clear, scaled by the prescaler
    a_ts_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        chk_ts_bound && hs |-> int'(evt.timestamp) <= (cyc - clr_cyc) / (ts_div_sh + 1))
        else begin
            errors++;
            $display("Error: evt_o.timestamp = 0x%h, bound 0x%h after clear",
                     $sampled(evt.timestamp), ($sampled(cyc) - clr_cyc) / (ts_div_sh + 1));
        end

    initial begin
        void'($urandom(33));
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        apb_req   = '0;
        req       = '0;
        evt_ready = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // requests pending but core disabled, registers at reset values
        evt_ready    = 1'b1;
        req          = all_on();
        chk_disabled = 1'b1;
        check_reg(`AER_REG_CTRL, 32'h0, "CTRL");
        check_reg(`AER_REG_POLMASK, 32'h3, "POLMASK");
        check_reg(`AER_REG_TSDIV, 32'h0, "TSDIV");
        check_reg(`AER_REG_EVTCNT, 32'h0, "EVTCNT");
        repeat (8) @(negedge clk_i);
        chk_disabled = 1'b0;

        // full sweep from reset pointers, ready held high
        chk_order = 1'b1;
        reg_write(`AER_REG_CTRL, 32'h1);
        run_batch(all_on(), 1'b0);
        chk_order = 1'b0;

        // polarity with both masks, then OFF only
        run_batch(mixed_batch(), 1'b0);
        reg_write(`AER_REG_POLMASK, 32'h2);
        on_sh = 1'b0;
        check_reg(`AER_REG_POLMASK, 32'h2, "POLMASK");
        run_batch(mixed_batch(), 1'b0);
        reg_write(`AER_REG_POLMASK, 32'h3);
        on_sh = 1'b1;

        // random requests against a random sink
        for (int k = 0; k < 3; k++) begin
            run_batch(random_batch(), 1'b1);
        end

        // prescaler 3, clear, then bounded timestamps
        reg_write(`AER_REG_TSDIV, 32'h3);
        ts_div_sh = 3;
        reg_write(`AER_REG_CTRL, 32'h3);
        // wall clock reaches 0 one edge after the pulse
        @(negedge clk_i);
        clr_cyc = cyc;
        clr_cnt++;
        chk_ts_bound = 1'b1;
        run_batch(all_on(), 1'b1);
        chk_ts_bound = 1'b0;

        // counter matches delivered events, core idle
        check_reg(`AER_REG_EVTCNT, 32'(hs_cnt), "EVTCNT");
        check_reg(`AER_REG_STATUS, 32'h0, "STATUS");

        $display("errors: %0d, events delivered: %0d", errors, hs_cnt);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: wall_clock.sv
// prescaled free-running timestamp counter with synchronous clear
`timescale 1ns/1ps
`include "aer_arbiter_consts.svh"

module wall_clock
    import aer_arbiter_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  aer_cfg_t             cfg_i,
    output logic [`AER_TS_W-1:0] timestamp_o
);

    // counts 0..ts_div, then one timestamp tick
    logic [7:0] div_cnt;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt     <= '0;
            timestamp_o <= '0;
        end else if (cfg_i.ts_clear) begin
            // restart both stages together
            div_cnt     <= '0;
            timestamp_o <= '0;
        end else if (div_cnt >= cfg_i.ts_div) begin
            div_cnt     <= '0;
            // wraps at full scale
            timestamp_o <= timestamp_o + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule
